//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
    --top-module mmio_uart_tb -o mmio_uart_sim &&
    ./obj_dir/mmio_uart_sim | tee /dev/stderr | grep '^Finished with no errors$' > /dev/null &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

//--- sim/mmio_golden.txt
// Columns: op (1 write, 2 read, 3 wait, f end), address, write data or wait cycles,
// expected prdata, expected pslverr
2 00 00000000 00000001 0
2 04 00000000 00000000 0
1 08 000000a5 00000000 0
1 08 0000003c 00000000 0
1 08 000000e1 00000000 0
3 00 00000140 00000000 0
2 00 00000000 00000003 0
2 04 00000000 000000a5 0
2 04 00000000 0000003c 0
2 04 00000000 000000e1 0
2 00 00000000 00000001 0
1 08 00000001 00000000 0
1 08 00000002 00000000 0
1 08 00000003 00000000 0
1 08 00000004 00000000 0
1 08 00000005 00000000 0
1 08 00000006 00000000 0
1 08 00000007 00000000 0
1 08 00000008 00000000 0
1 08 00000009 00000000 0
1 08 0000000a 00000000 0
2 00 00000000 00000000 0
3 00 000001a4 00000000 0
2 04 00000000 00000001 0
2 04 00000000 00000002 0
2 04 00000000 00000003 0
2 04 00000000 00000004 0
3 00 00000190 00000000 0
2 04 00000000 00000005 0
2 04 00000000 00000006 0
2 04 00000000 00000007 0
2 04 00000000 00000008 0
2 04 00000000 00000009 0
2 04 00000000 00000000 0
2 00 00000000 00000001 0
1 18 00000000 00000000 0
2 10 00000000 00000001 0
2 10 00000000 00000003 0
2 0c 00000000 00000000 1
1 20 00000055 00000000 1
2 00 00000000 00000001 0
f 00 00000000 00000000 0

//--- sim/mmio_uart_checker.sv
`timescale 1ns/1ns

module mmio_uart_checker (
    input logic               clk,
    input logic               rst_n,
    input mmio_pkg::apb_req_t apb_req,
    input mmio_pkg::apb_rsp_t apb_rsp,
    input logic               serial_tx
);

    int   fail_count;
    logic setup_cycle;

    initial fail_count = 0;

    assign setup_cycle = apb_req.psel && !apb_req.penable;

    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> $past(setup_cycle))
        else begin $error("penable without a setup cycle before it"); fail_count++; end

    paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> $stable(apb_req.paddr))
        else begin $error("paddr changed between setup and access"); fail_count++; end

    // First reset cycle skipped, state not yet cleared
    tx_idle_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> serial_tx)
        else begin $error("serial_tx low during reset"); fail_count++; end

    pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_req.penable)
        else begin $error("pslverr outside an access cycle"); fail_count++; end

endmodule

bind mmio_uart_top mmio_uart_checker checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .serial_tx (serial_tx)
);

//--- sim/mmio_uart_tb.sv
`timescale 1ns/1ns

module mmio_uart_tb;

    localparam int CLOCK_FREQ   = 80;
    localparam int BAUD_RATE    = 10;           // 8 clocks per bit
    localparam int FIFO_DEPTH   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int LINE_CYCLES  = 12 * 80;      // 12 frames per stimulus entry
    localparam int FIELDS       = 5;            // Columns per entry
    localparam int MAX_LINES    = 100;
    localparam int IDX_W        = 9;

    localparam mmio_pkg::word_t OP_WRITE = 32'h1;
    localparam mmio_pkg::word_t OP_READ  = 32'h2;
    localparam mmio_pkg::word_t OP_WAIT  = 32'h3;

    logic               clk;
    logic               rst_n;
    mmio_pkg::apb_req_t apb_req;
    mmio_pkg::apb_rsp_t apb_rsp;
    logic               serial_line;            // TX looped back to RX

    mmio_pkg::word_t golden [0:511];
    int              num_lines;
    int              error_count;
    int              check_count;
    mmio_pkg::word_t rd_data;
    logic            rd_err;
    logic            rd_ready;

    mmio_uart_top #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .serial_rx (serial_line),
        .serial_tx (serial_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mmio_pkg::word_t golden_field(input int entry, input int col);
        logic [IDX_W-1:0] idx;
        idx = IDX_W'(entry * FIELDS + col);
        return golden[idx];
    endfunction

    function automatic logic is_operation(input mmio_pkg::word_t op);
        return (op == OP_WRITE) || (op == OP_READ) || (op == OP_WAIT);
    endfunction

    task automatic check_value(input mmio_pkg::word_t actual, input mmio_pkg::word_t expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Setup cycle, then one access cycle
    task automatic apb_transfer(input logic write, input mmio_pkg::addr_t addr,
                                input mmio_pkg::word_t wdata);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rd_ready = apb_rsp.pready;
        rd_data  = apb_rsp.prdata;
        rd_err   = apb_rsp.pslverr;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            apb_req <= '0;  // Bus released
        end
    endtask

    initial begin
        int              line;
        mmio_pkg::word_t op;
        mmio_pkg::word_t wdata;
        string           where;

        rst_n       <= 1'b0;
        apb_req     <= '0;
        error_count = 0;
        check_count = 0;
        $readmemh("sim/mmio_golden.txt", golden);
        line = 0;
        while (line < MAX_LINES && is_operation(golden_field(line, 0))) begin
            line++;
        end
        num_lines = line;
        if (num_lines == 0) begin
            $display("No stimulus entries were read from sim/mmio_golden.txt");
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (line = 0; line < num_lines; line++) begin
            op    = golden_field(line, 0);
            wdata = golden_field(line, 2);
            where = $sformatf("entry %0d at address %h", line + 1, golden_field(line, 1));
            if (op == OP_WAIT) begin
                idle_cycles(int'(wdata));
            end else begin
                apb_transfer(op == OP_WRITE, mmio_pkg::addr_t'(golden_field(line, 1)), wdata);
                check_value(mmio_pkg::word_t'(rd_ready), 32'h1, {where, " pready"});
                check_value(rd_data, golden_field(line, 3), {where, " prdata"});
                check_value(mmio_pkg::word_t'(rd_err), golden_field(line, 4),
                            {where, " pslverr"});
            end
        end
        idle_cycles(2);

        if (UUT.checks.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", UUT.checks.fail_count);
            error_count += UUT.checks.fail_count;
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        int limit;

        wait (num_lines > 0);
        limit = num_lines * LINE_CYCLES + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout: the stimulus did not complete within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- src/apb_regs.sv
`timescale 1ns/1ns

module apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_pkg::apb_req_t  apb_req,
    output mmio_pkg::apb_rsp_t  apb_rsp,
    output logic                tx_push,
    output mmio_pkg::byte_t     tx_data,
    input  logic                tx_full,
    output logic                rx_pop,
    input  mmio_pkg::byte_t     rx_data,
    input  logic                rx_empty
);

    mmio_pkg::word_t cycle_cnt;
    mmio_pkg::word_t rdata;
    logic            access;     // Second cycle of a transfer
    logic            wr_access;
    logic            rd_access;
    logic            mapped;
    logic            cnt_clear;

    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    // Side effects fire in the access cycle only
    assign tx_push   = wr_access && (apb_req.paddr == mmio_pkg::UART_TX_ADDR) && !tx_full;
    assign tx_data   = apb_req.pwdata[7:0];
    assign rx_pop    = rd_access && (apb_req.paddr == mmio_pkg::UART_RX_ADDR) && !rx_empty;
    assign cnt_clear = wr_access && (apb_req.paddr == mmio_pkg::CNT_RST_ADDR);

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb_req.paddr)
            mmio_pkg::UART_CTRL_ADDR: begin
                rdata[0] = !tx_full;   // Transmit ready
                rdata[1] = !rx_empty;  // Receive valid
            end
            mmio_pkg::UART_RX_ADDR: begin
                if (!rx_empty) begin
                    rdata = mmio_pkg::word_t'(rx_data);
                end
            end
            mmio_pkg::UART_TX_ADDR: begin
                rdata = '0;  // Write only
            end
            mmio_pkg::CYCLE_ADDR: begin
                rdata = cycle_cnt;  // Value before this cycle's increment
            end
            mmio_pkg::CNT_RST_ADDR: begin
                rdata = '0;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign apb_rsp.pready  = 1'b1;  // No wait states
    assign apb_rsp.pslverr = access && !mapped;
    assign apb_rsp.prdata  = rdata;

    // Free-running, cleared by a write to CNT_RST_ADDR
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (cnt_clear) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

//--- src/byte_fifo.sv
`timescale 1ns/1ns

module byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  mmio_pkg::byte_t     push_data,
    output logic                full,
    input  logic                pop,
    output mmio_pkg::byte_t     pop_data,
    output logic                empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    mmio_pkg::byte_t mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;  // Extra bit tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign do_push = push && !full;   // Drop when full
    assign do_pop  = pop && !empty;   // Ignore when empty

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign pop_data = mem[rd_ptr[AW-1:0]];  // Head of queue

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- src/mmio_pkg.sv
package mmio_pkg;

    typedef logic [31:0] word_t;  // APB data word
    typedef logic [7:0]  addr_t;  // APB byte address
    typedef logic [7:0]  byte_t;  // Serial payload

    // Register map
    localparam addr_t UART_CTRL_ADDR = 8'h00;  // Status, read only
    localparam addr_t UART_RX_ADDR   = 8'h04;  // Read pops receive FIFO
    localparam addr_t UART_TX_ADDR   = 8'h08;  // Write pushes transmit FIFO
    localparam addr_t CYCLE_ADDR     = 8'h10;  // Cycle counter value
    localparam addr_t CNT_RST_ADDR   = 8'h18;  // Any write clears counter

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        logic  pslverr;
        word_t prdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_t;

endpackage

//--- src/mmio_uart_top.sv
`timescale 1ns/1ns

module mmio_uart_top #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_pkg::apb_req_t  apb_req,
    output mmio_pkg::apb_rsp_t  apb_rsp,
    input  logic                serial_rx,
    output logic                serial_tx
);

    // Bus to transmitter
    logic            tx_push;
    mmio_pkg::byte_t tx_data;
    logic            tx_full;
    logic            tx_pop;
    mmio_pkg::byte_t tx_head;
    logic            tx_empty;
    logic            tx_ready;

    // Receiver to bus
    mmio_pkg::byte_t rx_byte;
    logic            rx_valid;
    logic            rx_push;
    logic            rx_full;
    logic            rx_pop;
    mmio_pkg::byte_t rx_head;
    logic            rx_empty;

    assign tx_pop  = !tx_empty && tx_ready;   // Byte moves to transmitter
    assign rx_push = rx_valid && !rx_full;    // Lost when queue is full

    apb_regs regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .tx_full  (tx_full),
        .rx_pop   (rx_pop),
        .rx_data  (rx_head),
        .rx_empty (rx_empty)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_data),
        .full      (tx_full),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .empty     (tx_empty)
    );

    uart_tx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .data       (tx_head),
        .valid      (!tx_empty),
        .ready      (tx_ready),
        .serial_out (serial_tx)
    );

    uart_rx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .serial_in (serial_rx),
        .data      (rx_byte),
        .valid     (rx_valid)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_byte),
        .full      (rx_full),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .empty     (rx_empty)
    );

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             serial_in,
    output mmio_pkg::byte_t  data,
    output logic             valid
);

    localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W          = $clog2(CLOCKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLOCKS_PER_BIT / 2 - 1);

    mmio_pkg::rx_state_t state;
    logic [1:0]          sync;      // Two-flop synchronizer
    logic                rx_bit;
    logic [CNT_W-1:0]    bit_cnt;
    logic [2:0]          bit_idx;
    mmio_pkg::byte_t     shift;
    logic                bit_done;

    assign rx_bit   = sync[1];
    assign bit_done = (bit_cnt == BIT_LAST);
    assign data     = shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync <= 2'b11;  // Line idles high
        end else begin
            sync <= {sync[0], serial_in};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= mmio_pkg::RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            valid   <= 1'b0;
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                mmio_pkg::RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_bit) begin
                        state <= mmio_pkg::RX_START;  // Falling edge seen
                    end
                end
                mmio_pkg::RX_START: begin
                    if (bit_cnt == HALF_LAST) begin
                        bit_cnt <= '0;  // Realign to mid-bit
                        bit_idx <= '0;
                        state   <= rx_bit ? mmio_pkg::RX_IDLE : mmio_pkg::RX_DATA;
                    end
                end
                mmio_pkg::RX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= mmio_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        valid <= rx_bit;  // Framing error drops byte
                        state <= mmio_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Sampled LSB first
    always_ff @(posedge clk) begin
        if (state == mmio_pkg::RX_DATA && bit_done) begin
            shift <= {rx_bit, shift[7:1]};
        end
    end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic             clk,
    input  logic             rst_n,
    input  mmio_pkg::byte_t  data,
    input  logic             valid,
    output logic             ready,
    output logic             serial_out
);

    localparam int CLOCKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W          = $clog2(CLOCKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLOCKS_PER_BIT - 1);

    mmio_pkg::tx_state_t state;
    logic [CNT_W-1:0]    bit_cnt;   // Clocks within current bit
    logic [2:0]          bit_idx;   // Data bit being sent
    mmio_pkg::byte_t     shift;
    logic                bit_done;

    assign ready    = (state == mmio_pkg::TX_IDLE);
    assign bit_done = (bit_cnt == BIT_LAST);

    always_comb begin
        case (state)
            mmio_pkg::TX_START: serial_out = 1'b0;
            mmio_pkg::TX_DATA:  serial_out = shift[0];  // LSB first
            default:            serial_out = 1'b1;      // Idle and stop are high
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= mmio_pkg::TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                mmio_pkg::TX_IDLE: begin
                    bit_cnt <= '0;
                    if (valid) begin
                        state <= mmio_pkg::TX_START;
                    end
                end
                mmio_pkg::TX_START: begin
                    if (bit_done) begin
                        state   <= mmio_pkg::TX_DATA;
                        bit_idx <= '0;
                    end
                end
                mmio_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= mmio_pkg::TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= mmio_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ready && valid) begin
            shift <= data;  // Latch byte on accept
        end else if (state == mmio_pkg::TX_DATA && bit_done) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

//--- verilog.f
src/mmio_pkg.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/apb_regs.sv
src/mmio_uart_top.sv
sim/mmio_uart_checker.sv
sim/mmio_uart_tb.sv
